//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = soc_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Some tests failed
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation FAILED, no verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/soc_props.sv
`timescale 1ns/10ps
`default_nettype none

module soc_props import soc_pkg::*; (
    input wire          ck,
    input wire          rst_n,
    input wire          cyc,
    input wire          strobe,
    input wire          ack,
    input wire periph_e periph
);

    // Single-beat bus, ack is a one-cycle pulse
    ack_single: assert property (@(posedge ck) disable iff (!rst_n) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    ack_in_cycle: assert property (@(posedge ck) disable iff (!rst_n) ack |-> cyc)
        else $error("ack high while cyc is low");

    // Only UART accesses may stall
    ack_latency: assert property (@(posedge ck) disable iff (!rst_n)
        ($past(strobe, 2) && ($past(periph, 2) != PERIPH_UART) && !$past(ack)) |-> ack)
        else $error("no ack within 2 cycles of a non-UART strobe");

endmodule

bind soc soc_props u_props (
    .ck(ck), .rst_n(rst_n), .cyc(cyc),
    .strobe(strobe), .ack(ack), .periph(periph)
);

`default_nettype wire

//--- bench/soc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module soc_tb;

    localparam int PERIOD          = 40;
    localparam int BAUD            = 8;
    localparam int FRAME_CYCLES    = 10 * BAUD;
    localparam int ACCESS_LIMIT    = 3 * FRAME_CYCLES;
    // Bus accesses issued by all tests together
    localparam int N_ACCESS        = 74;
    localparam int WATCHDOG_CYCLES = N_ACCESS * 20 * FRAME_CYCLES;
    localparam logic [31:0] GPIO_ADR      = 32'h4000_0000;
    localparam logic [31:0] UART_DATA_ADR = 32'h6000_0000;
    localparam logic [31:0] UART_STAT_ADR = 32'h6000_0004;
    localparam logic [31:0] NONE_ADR      = 32'h1000_0000;

    logic        ck;
    logic        rst_n;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic [31:0] rdt;
    logic        ack;
    logic [7:0]  test;
    logic        led;
    logic        tx;
    logic [7:0]  gpio_model;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    soc uut (
        .ck(ck), .rst_n(rst_n), .adr(adr), .dat(dat), .sel(sel), .we(we), .cyc(cyc),
        .rdt(rdt), .ack(ack), .test(test), .led(led), .tx(tx)
    );

    initial begin
        ck = 1'b0;
        forever #(PERIOD / 2) ck = ~ck;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // One single-beat access with cyc held until ack is seen mid-cycle
    task automatic bus_access(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, input logic w,
                              output logic [31:0] data, output int lat);
        int n;
        n = 0;
        @(posedge ck);
        adr <= a;
        dat <= d;
        sel <= s;
        we  <= w;
        cyc <= 1'b1;
        @(negedge ck);
        while (!ack && n < ACCESS_LIMIT) begin
            @(negedge ck);
            n++;
        end
        data = rdt;
        lat  = n;
        assert (ack === 1'b1) else begin
            $display("** Error at %0t: no ack within %0d cycles for access to 0x%h",
                     $time, ACCESS_LIMIT, a);
            test_errors++;
        end
        // Probe bit 6 mirrors the held cyc
        check_value("test[6]", 32'(test[6]), 32'd1);
        @(posedge ck);
        cyc <= 1'b0;
        we  <= 1'b0;
    endtask

    // Waits for a start bit, then samples each bit in its middle
    task automatic receive_byte(output logic [7:0] b);
        int n;
        n = 0;
        @(negedge ck);
        while (tx !== 1'b0 && n < ACCESS_LIMIT) begin
            @(negedge ck);
            n++;
        end
        assert (tx === 1'b0) else begin
            $display("** Error at %0t: no start bit seen on tx", $time);
            test_errors++;
        end
        repeat (BAUD / 2) @(negedge ck);
        check_value("tx start bit", 32'(tx), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD) @(negedge ck);
            b[i] = tx;
        end
        repeat (BAUD) @(negedge ck);
        check_value("tx stop bit", 32'(tx), 32'd1);
        repeat (BAUD / 2) @(negedge ck);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %-28s errors: %0d", name, test_errors);
        test_errors = 0;
    endtask

    task automatic reset_state_test();
        logic [31:0] data;
        int          lat;
        @(negedge ck);
        check_value("ack", 32'(ack), 32'd0);
        check_value("tx", 32'(tx), 32'd1);
        check_value("led", 32'(led), 32'd0);
        check_value("test", 32'(test & 8'hbe), 32'd0);
        check_value("test[6]", 32'(test[6]), 32'd0);
        bus_access(GPIO_ADR, 32'd0, 4'hf, 1'b0, data, lat);
        check_value("rdt", data, 32'd0);
        finish_test("reset state");
    endtask

    task automatic gpio_test();
        logic [31:0] data;
        logic [31:0] val;
        int          lat;
        repeat (16) begin
            val = $urandom();
            bus_access(GPIO_ADR, val, 4'($urandom()) | 4'h1, 1'b1, data, lat);
            gpio_model = val[7:0];
            check_value("led", 32'(led), 32'(gpio_model[0]));
            bus_access(GPIO_ADR, 32'd0, 4'hf, 1'b0, data, lat);
            check_value("rdt", data, {24'd0, gpio_model});
            // Register holds with lane 0 disabled
            bus_access(GPIO_ADR, ~val, 4'($urandom()) & 4'he, 1'b1, data, lat);
            bus_access(GPIO_ADR, 32'd0, 4'hf, 1'b0, data, lat);
            check_value("rdt", data, {24'd0, gpio_model});
        end
        finish_test("gpio write and readback");
    endtask

    task automatic uart_frame_test();
        logic [31:0] data;
        logic [9:0]  frame;
        int          lat;
        frame = {1'b1, 8'($urandom()), 1'b0};
        bus_access(UART_DATA_ADR, {24'd0, frame[8:1]}, 4'h1, 1'b1, data, lat);
        // Start bit began in the ack cycle
        repeat (BAUD / 2) @(negedge ck);
        for (int i = 0; i < 10; i++) begin
            check_value("tx", 32'(tx), 32'(frame[i]));
            check_value("test[0]", 32'(test[0]), 32'(frame[i]));
            repeat (BAUD) @(negedge ck);
        end
        finish_test("uart frame");
    endtask

    task automatic uart_backpressure_test();
        logic [31:0] data;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  r0;
        logic [7:0]  r1;
        time         t_a;
        time         t_b;
        int          lat;
        b0 = 8'($urandom());
        b1 = 8'($urandom());
        fork
            begin
                receive_byte(r0);
                receive_byte(r1);
            end
            begin
                bus_access(UART_DATA_ADR, {24'd0, b0}, 4'h1, 1'b1, data, lat);
                t_a = $time;
                bus_access(UART_STAT_ADR, 32'd0, 4'hf, 1'b0, data, lat);
                check_value("status busy", data, 32'd1);
                bus_access(UART_DATA_ADR, {24'd0, b1}, 4'h1, 1'b1, data, lat);
                t_b = $time;
            end
        join
        assert ((t_b - t_a) >= 64'(FRAME_CYCLES * PERIOD)) else begin
            $display("** Error at %0t: second UART write acked before first frame ended",
                     $time);
            test_errors++;
        end
        check_value("first byte", 32'(r0), 32'(b0));
        check_value("second byte", 32'(r1), 32'(b1));
        bus_access(UART_STAT_ADR, 32'd0, 4'hf, 1'b0, data, lat);
        check_value("status idle", data, 32'd0);
        finish_test("uart status and back-pressure");
    endtask

    task automatic unmapped_test();
        logic [31:0] data;
        int          lat;
        bus_access(NONE_ADR | 32'h8, 32'd0, 4'hf, 1'b0, data, lat);
        check_value("rdt", data, 32'd0);
        bus_access(NONE_ADR, {24'd0, ~gpio_model}, 4'hf, 1'b1, data, lat);
        check_value("rdt", data, 32'd0);
        check_value("tx", 32'(tx), 32'd1);
        bus_access(GPIO_ADR, 32'd0, 4'hf, 1'b0, data, lat);
        check_value("rdt", data, {24'd0, gpio_model});
        finish_test("unmapped address");
    endtask

    task automatic latency_test();
        logic [31:0] data;
        int          lat;
        bus_access(GPIO_ADR, 32'd0, 4'hf, 1'b0, data, lat);
        check_value("latency", 32'(lat), 32'd2);
        finish_test("access latency");
    endtask

    initial begin
        void'($urandom(32'h91b69ceb));
        rst_n <= 1'b0;
        adr   <= 32'd0;
        dat   <= 32'd0;
        sel   <= 4'd0;
        we    <= 1'b0;
        cyc   <= 1'b0;
        gpio_model   = 8'h00;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge ck);
        rst_n <= 1'b1;
        reset_state_test();
        gpio_test();
        uart_frame_test();
        uart_backpressure_test();
        unmapped_test();
        latency_test();
        $display("Tests run: %0d, failing: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ck);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decode import soc_pkg::*; #(
    parameter logic [7:0] GPIO_BASE = 8'h40,
    parameter logic [7:0] UART_BASE = 8'h60
) (
    input  wire            ck,
    input  wire            rst_n,
    input  wire     [31:0] adr,
    input  wire     [31:0] dat,
    input  wire     [3:0]  sel,
    input  wire            we,
    input  wire            cyc,
    input  wire            done,
    output logic           strobe,
    output periph_e        periph,
    output bus_op_e        op,
    output logic    [1:0]  reg_sel,
    output logic    [31:0] wdata,
    output logic    [3:0]  wsel
);

    logic    busy;
    logic    take;
    periph_e periph_nxt;

    // One decode per held cyc, none while an access is in flight
    assign take = cyc && !busy && !strobe;

    always_comb begin
        if (adr[31:24] == GPIO_BASE) begin
            periph_nxt = PERIPH_GPIO;
        end else if (adr[31:24] == UART_BASE) begin
            periph_nxt = PERIPH_UART;
        end else begin
            periph_nxt = PERIPH_NONE;
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            strobe <= 1'b0;
            busy   <= 1'b0;
            periph <= PERIPH_NONE;
            op     <= OP_READ;
        end else begin
            strobe <= take;
            if (strobe) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (take) begin
                periph <= periph_nxt;
                op     <= we ? OP_WRITE : OP_READ;
            end
        end
    end

    // Access payload
    always_ff @(posedge ck) begin
        if (take) begin
            reg_sel <= adr[3:2];
            wdata   <= dat;
            wsel    <= sel;
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_return.sv
`timescale 1ns/10ps
`default_nettype none

module bus_return import soc_pkg::*; (
    input  wire            ck,
    input  wire            rst_n,
    input  wire            strobe,
    input  wire periph_e   periph,
    input  wire     [31:0] gpio_rdt,
    input  wire            gpio_ack,
    input  wire     [31:0] uart_rdt,
    input  wire            uart_ack,
    output logic    [31:0] rdt,
    output logic           ack,
    output logic           done
);

    logic ack_none;
    logic ack_any;

    // Unmapped accesses still complete, so the CPU never stalls
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            ack_none <= 1'b0;
        end else begin
            ack_none <= strobe && (periph == PERIPH_NONE);
        end
    end

    assign ack_any = gpio_ack | uart_ack | ack_none;

    assign ack  = ack_any;
    assign done = ack_any;

    // Idle peripherals contribute nothing to the merged data
    assign rdt = ({32{gpio_ack}} & gpio_rdt) | ({32{uart_ack}} & uart_rdt);

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_port import soc_pkg::*; (
    input  wire            ck,
    input  wire            rst_n,
    input  wire            strobe,
    input  wire periph_e   periph,
    input  wire bus_op_e   op,
    input  wire     [1:0]  reg_sel,
    input  wire     [31:0] wdata,
    input  wire     [3:0]  wsel,
    output logic    [7:0]  gpio,
    output logic    [31:0] rdt,
    output logic           ack
);

    logic hit;
    logic wr_en;
    logic rd_data;

    assign hit = strobe && (periph == PERIPH_GPIO);

    // Only byte lane 0 reaches the register
    assign wr_en = hit && (op == OP_WRITE) && (reg_sel == REG_DATA) && wsel[0];

    assign rd_data = (op == OP_READ) && (reg_sel == REG_DATA);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            gpio <= 8'h00;
            ack  <= 1'b0;
        end else begin
            ack <= hit;
            if (wr_en) begin
                gpio <= wdata[7:0];
            end
        end
    end

    // Readback, valid alongside ack
    always_ff @(posedge ck) begin
        if (hit) begin
            if (rd_data) begin
                rdt <= {24'h000000, gpio};
            end else begin
                rdt <= 32'h00000000;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/soc.sv
`timescale 1ns/10ps
`default_nettype none

module soc import soc_pkg::*; #(
    parameter logic [7:0]  GPIO_BASE   = 8'h40,
    parameter logic [7:0]  UART_BASE   = 8'h60,
    parameter logic [15:0] BAUD_DIVIDE = 16'd8
) (
    input  wire        ck,
    input  wire        rst_n,
    // CPU data bus
    input  wire [31:0] adr,
    input  wire [31:0] dat,
    input  wire [3:0]  sel,
    input  wire        we,
    input  wire        cyc,
    output logic [31:0] rdt,
    output logic        ack,
    // Board pins
    output logic [7:0]  test,
    output logic        led,
    output logic        tx
);

    logic        strobe;
    periph_e     periph;
    bus_op_e     op;
    logic [1:0]  reg_sel;
    logic [31:0] wdata;
    logic [3:0]  wsel;
    logic        done;
    logic [7:0]  gpio;
    logic [31:0] gpio_rdt;
    logic        gpio_ack;
    logic [31:0] uart_rdt;
    logic        uart_ack;

    bus_decode #(
        .GPIO_BASE(GPIO_BASE),
        .UART_BASE(UART_BASE)
    ) u_decode (
        .ck(ck), .rst_n(rst_n),
        .adr(adr), .dat(dat), .sel(sel), .we(we), .cyc(cyc), .done(done),
        .strobe(strobe), .periph(periph), .op(op),
        .reg_sel(reg_sel), .wdata(wdata), .wsel(wsel)
    );

    gpio_port u_gpio (
        .ck(ck), .rst_n(rst_n),
        .strobe(strobe), .periph(periph), .op(op),
        .reg_sel(reg_sel), .wdata(wdata), .wsel(wsel),
        .gpio(gpio), .rdt(gpio_rdt), .ack(gpio_ack)
    );

    uart_tx #(
        .BAUD_DIVIDE(BAUD_DIVIDE)
    ) u_uart (
        .ck(ck), .rst_n(rst_n),
        .strobe(strobe), .periph(periph), .op(op),
        .reg_sel(reg_sel), .wdata(wdata),
        .tx(tx), .rdt(uart_rdt), .ack(uart_ack)
    );

    bus_return u_return (
        .ck(ck), .rst_n(rst_n),
        .strobe(strobe), .periph(periph),
        .gpio_rdt(gpio_rdt), .gpio_ack(gpio_ack),
        .uart_rdt(uart_rdt), .uart_ack(uart_ack),
        .rdt(rdt), .ack(ack), .done(done)
    );

    assign led = gpio[0];

    // Scope probe header
    assign test[0] = tx;
    assign test[1] = 1'b0;
    assign test[2] = 1'b0;
    assign test[3] = 1'b0;
    assign test[4] = 1'b0;
    assign test[5] = 1'b0;
    assign test[6] = cyc;
    assign test[7] = 1'b0;

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Peripheral chosen by the address decoder
    typedef enum logic [1:0] {
        PERIPH_NONE = 2'd0,
        PERIPH_GPIO = 2'd1,
        PERIPH_UART = 2'd2
    } periph_e;

    // Direction of a decoded access
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Transmitter frame states
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

    // Register offsets, as address bits 3:2
    localparam logic [1:0] REG_DATA   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;

endpackage

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import soc_pkg::*; #(
    parameter logic [15:0] BAUD_DIVIDE = 16'd8
) (
    input  wire             ck,
    input  wire             rst_n,
    input  wire             strobe,
    input  wire periph_e    periph,
    input  wire bus_op_e    op,
    input  wire      [1:0]  reg_sel,
    input  wire      [31:0] wdata,
    output logic            tx,
    output logic     [31:0] rdt,
    output logic            ack
);

    uart_state_e state;
    logic [15:0] baud_cnt;
    logic [7:0]  shifter;
    logic [2:0]  bit_cnt;
    logic        pending;
    logic [7:0]  pend_data;
    logic        hit;
    logic        data_wr;
    logic        accept;
    logic        busy;
    logic        bit_end;

    assign hit     = strobe && (periph == PERIPH_UART);
    assign data_wr = hit && (op == OP_WRITE) && (reg_sel == REG_DATA);
    assign busy    = (state != UART_IDLE) || pending;
    assign bit_end = (baud_cnt == 16'd0);

    // A held write starts as soon as the line is idle again
    assign accept = (state == UART_IDLE) && (data_wr || pending);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            pending <= 1'b0;
            ack     <= 1'b0;
        end else begin
            // Data writes are acked on acceptance, everything else at once
            ack <= (hit && !data_wr) || accept;
            if (accept) begin
                pending <= 1'b0;
            end else if (data_wr) begin
                pending <= 1'b1;
            end
            case (state)
                UART_IDLE: begin
                    if (accept) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end && (bit_cnt == 3'd7)) begin
                        state <= UART_STOP;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state <= UART_IDLE;
                    end
                end
                default: begin
                    state <= UART_IDLE;
                end
            endcase
        end
    end

    // Baud timing and shift register
    always_ff @(posedge ck) begin
        if (data_wr && !accept) begin
            pend_data <= wdata[7:0];
        end
        if (accept) begin
            shifter  <= pending ? pend_data : wdata[7:0];
            baud_cnt <= BAUD_DIVIDE - 16'd1;
            bit_cnt  <= 3'd0;
        end else if (state != UART_IDLE) begin
            if (bit_end) begin
                baud_cnt <= BAUD_DIVIDE - 16'd1;
                if (state == UART_DATA) begin
                    shifter <= {1'b0, shifter[7:1]};
                    bit_cnt <= bit_cnt + 3'd1;
                end
            end else begin
                baud_cnt <= baud_cnt - 16'd1;
            end
        end
    end

    // Status readback
    always_ff @(posedge ck) begin
        if (hit) begin
            if ((op == OP_READ) && (reg_sel == REG_STATUS)) begin
                rdt <= {31'h00000000, busy};
            end else begin
                rdt <= 32'h00000000;
            end
        end
    end

    // Line level, LSB first
    always_comb begin
        case (state)
            UART_START: tx = 1'b0;
            UART_DATA:  tx = shifter[0];
            default:    tx = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- tb.f
logic/soc_pkg.sv
logic/bus_decode.sv
logic/gpio_port.sv
logic/uart_tx.sv
logic/bus_return.sv
logic/soc.sv
bench/soc_props.sv
bench/soc_tb.sv
